// File: hw/board_pad_pkg.sv
// Pad types for a 16-bit BPI flash with 23-bit word address, five open-drain I2C lines, two SFP cages
package board_pad_pkg;

    // Flash bus
    typedef logic [15:0] flash_data_t;
    typedef logic [22:0] flash_addr_t;

    // Open-drain I2C lines, one bit each
    localparam int I2C_LINES = 5;

    typedef logic [I2C_LINES-1:0] i2c_lines_t;

    // Bit positions within i2c_lines_t
    localparam int I2C_SFP_SCL    = 0;
    localparam int I2C_SFP1_SDA   = 1;
    localparam int I2C_SFP2_SDA   = 2;
    localparam int I2C_EEPROM_SCL = 3;
    localparam int I2C_EEPROM_SDA = 4;

    // {sfp_1_npres, sfp_2_npres, sfp_1_los, sfp_2_los}
    typedef logic [3:0] sfp_status_t;

    // Depth of the pad input synchronizers
    localparam int SYNC_STAGES = 2;

endpackage

// File: hw/icap_cmd_pkg.sv
// Command words for a 32-bit configuration port; words are given in port order before bit reversal
package icap_cmd_pkg;

    typedef logic [31:0] icap_word_t;

    // Reboot command set
    localparam icap_word_t ICAP_DUMMY     = 32'hFFFF_FFFF;
    localparam icap_word_t ICAP_SYNC      = 32'hAA99_5566;
    // Type 1 packet, no-op
    localparam icap_word_t ICAP_NOOP      = 32'h2000_0000;
    // Type 1 write, one word to CMD register
    localparam icap_word_t ICAP_CMD_WRITE = 32'h3000_8001;
    localparam icap_word_t ICAP_IPROG     = 32'h0000_000F;

    // Boot request crosses in from a slow external source
    localparam int BOOT_SYNC_STAGES = 3;

    // Each state names the word on the port while in it
    typedef enum logic [2:0] {
        ST_IDLE,
        ST_DUMMY,
        ST_SYNC,
        ST_NOOP,
        ST_CMD,
        ST_IPROG,
        ST_TAIL
    } reboot_state_t;

endpackage

// File: hw/pad_input_sync.sv
// Plain flop chains, no glitch filtering; multi-bit inputs are not coherent across bits
module pad_input_sync (
    input  logic                       pcie_user_clk,
    input  logic                       arst_n_i,

    input  logic                       fpga_boot_i,
    input  board_pad_pkg::sfp_status_t sfp_status_i,
    input  board_pad_pkg::i2c_lines_t  i2c_pad_i,
    input  board_pad_pkg::flash_data_t flash_dq_pad_i,

    output logic                       boot_req_o,
    output board_pad_pkg::sfp_status_t sfp_status_sync_o,
    output board_pad_pkg::i2c_lines_t  i2c_sync_o,
    output board_pad_pkg::flash_data_t flash_dq_sync_o
);

    import board_pad_pkg::*;
    import icap_cmd_pkg::*;

    logic [BOOT_SYNC_STAGES-1:0] boot_q;

    sfp_status_t status_q [SYNC_STAGES];
    i2c_lines_t  i2c_q    [SYNC_STAGES];
    flash_data_t dq_q     [SYNC_STAGES];

    always_ff @(posedge pcie_user_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            boot_q <= '0;
            for (int i = 0; i < SYNC_STAGES; i++) begin
                status_q[i] <= '0;
                i2c_q[i]    <= '0;
                dq_q[i]     <= '0;
            end
        end else begin
            // Shift in at bit 0
            boot_q <= {boot_q[BOOT_SYNC_STAGES-2:0], fpga_boot_i};

            status_q[0] <= sfp_status_i;
            i2c_q[0]    <= i2c_pad_i;
            dq_q[0]     <= flash_dq_pad_i;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                status_q[i] <= status_q[i-1];
                i2c_q[i]    <= i2c_q[i-1];
                dq_q[i]     <= dq_q[i-1];
            end
        end
    end

    assign boot_req_o        = boot_q[BOOT_SYNC_STAGES-1];
    assign sfp_status_sync_o = status_q[SYNC_STAGES-1];
    assign i2c_sync_o        = i2c_q[SYNC_STAGES-1];
    assign flash_dq_sync_o   = dq_q[SYNC_STAGES-1];

endmodule

// File: hw/icap_reboot_seq.sv
// Availability is checked only at start; a started sequence always runs to the end
module icap_reboot_seq (
    input  logic                    pcie_user_clk,
    input  logic                    arst_n_i,

    input  logic                    boot_req_i,
    input  logic                    icap_avail_i,

    output logic                    icap_csib_o,
    output logic                    icap_rdwrb_o,
    output icap_cmd_pkg::icap_word_t icap_di_o
);

    import icap_cmd_pkg::*;

    reboot_state_t state_q;
    icap_word_t    word_q;
    logic          csib_q;

    always_ff @(posedge pcie_user_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= ST_IDLE;
            word_q  <= ICAP_DUMMY;
            csib_q  <= 1'b1;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    csib_q <= 1'b1;
                    word_q <= ICAP_DUMMY;
                    if (boot_req_i && icap_avail_i) begin
                        state_q <= ST_DUMMY;
                        csib_q  <= 1'b0;
                    end
                end
                ST_DUMMY: begin
                    state_q <= ST_SYNC;
                    word_q  <= ICAP_SYNC;
                end
                ST_SYNC: begin
                    state_q <= ST_NOOP;
                    word_q  <= ICAP_NOOP;
                end
                ST_NOOP: begin
                    state_q <= ST_CMD;
                    word_q  <= ICAP_CMD_WRITE;
                end
                ST_CMD: begin
                    state_q <= ST_IPROG;
                    word_q  <= ICAP_IPROG;
                end
                ST_IPROG: begin
                    // Trailing no-op flushes the IPROG
                    state_q <= ST_TAIL;
                    word_q  <= ICAP_NOOP;
                end
                ST_TAIL: begin
                    state_q <= ST_IDLE;
                    csib_q  <= 1'b1;
                    word_q  <= ICAP_DUMMY;
                end
                default: begin
                    state_q <= ST_IDLE;
                    csib_q  <= 1'b1;
                    word_q  <= ICAP_DUMMY;
                end
            endcase
        end
    end

    // Port takes each byte MSB first, byte order unchanged
    always_comb begin
        for (int b = 0; b < $bits(icap_word_t) / 8; b++) begin
            for (int i = 0; i < 8; i++) begin
                icap_di_o[8*b + i] = word_q[8*b + 7 - i];
            end
        end
    end

    assign icap_csib_o  = csib_q;
    // Write direction only
    assign icap_rdwrb_o = 1'b0;

endmodule

// File: hw/pad_output_stage.sv
// One register per output, no output-enable glitch protection; flash address is unknown until first clock
module pad_output_stage (
    input  logic                       pcie_user_clk,
    input  logic                       arst_n_i,

    input  board_pad_pkg::i2c_lines_t  i2c_o_i,
    input  board_pad_pkg::i2c_lines_t  i2c_t_i,
    inout  wire                        sfp_i2c_scl_io,
    inout  wire                        sfp_1_i2c_sda_io,
    inout  wire                        sfp_2_i2c_sda_io,
    inout  wire                        eeprom_i2c_scl_io,
    inout  wire                        eeprom_i2c_sda_io,

    input  board_pad_pkg::flash_data_t flash_dq_o_i,
    input  logic                       flash_dq_oe_i,
    input  board_pad_pkg::flash_addr_t flash_addr_i,
    input  logic                       flash_region_i,
    input  logic                       flash_region_oe_i,
    input  logic                       flash_ce_n_i,
    input  logic                       flash_oe_n_i,
    input  logic                       flash_we_n_i,
    input  logic                       flash_adv_n_i,

    inout  wire board_pad_pkg::flash_data_t flash_dq_io,
    inout  wire                        flash_region_io,
    output board_pad_pkg::flash_addr_t flash_addr_o,
    output logic                       flash_ce_n_o,
    output logic                       flash_oe_n_o,
    output logic                       flash_we_n_o,
    output logic                       flash_adv_n_o
);

    import board_pad_pkg::*;

    i2c_lines_t  i2c_o_q;
    i2c_lines_t  i2c_t_q;
    flash_data_t dq_o_q;
    logic        dq_oe_q;
    logic        region_q;
    logic        region_oe_q;

    // Enables and strobes come out of reset inactive
    always_ff @(posedge pcie_user_clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            i2c_t_q       <= '1;
            dq_oe_q       <= 1'b0;
            region_oe_q   <= 1'b0;
            flash_ce_n_o  <= 1'b1;
            flash_oe_n_o  <= 1'b1;
            flash_we_n_o  <= 1'b1;
            flash_adv_n_o <= 1'b1;
        end else begin
            i2c_t_q       <= i2c_t_i;
            dq_oe_q       <= flash_dq_oe_i;
            region_oe_q   <= flash_region_oe_i;
            flash_ce_n_o  <= flash_ce_n_i;
            flash_oe_n_o  <= flash_oe_n_i;
            flash_we_n_o  <= flash_we_n_i;
            flash_adv_n_o <= flash_adv_n_i;
        end
    end

    always_ff @(posedge pcie_user_clk) begin
        i2c_o_q      <= i2c_o_i;
        dq_o_q       <= flash_dq_o_i;
        region_q     <= flash_region_i;
        flash_addr_o <= flash_addr_i;
    end

    // Open-drain, released while tristate bit is high
    assign sfp_i2c_scl_io    = i2c_t_q[I2C_SFP_SCL]    ? 1'bz : i2c_o_q[I2C_SFP_SCL];
    assign sfp_1_i2c_sda_io  = i2c_t_q[I2C_SFP1_SDA]   ? 1'bz : i2c_o_q[I2C_SFP1_SDA];
    assign sfp_2_i2c_sda_io  = i2c_t_q[I2C_SFP2_SDA]   ? 1'bz : i2c_o_q[I2C_SFP2_SDA];
    assign eeprom_i2c_scl_io = i2c_t_q[I2C_EEPROM_SCL] ? 1'bz : i2c_o_q[I2C_EEPROM_SCL];
    assign eeprom_i2c_sda_io = i2c_t_q[I2C_EEPROM_SDA] ? 1'bz : i2c_o_q[I2C_EEPROM_SDA];

    assign flash_dq_io     = dq_oe_q ? dq_o_q : 'z;
    assign flash_region_io = region_oe_q ? region_q : 1'bz;

endmodule

// File: hw/board_io_top.sv
// Single pcie_user_clk domain; configuration port primitive sits outside and connects via icap_* ports
module board_io_top (
    input  logic                       pcie_user_clk,
    input  logic                       arst_n_i,

    input  logic                       fpga_boot_i,
    input  logic                       icap_avail_i,
    output logic                       icap_csib_o,
    output logic                       icap_rdwrb_o,
    output icap_cmd_pkg::icap_word_t   icap_di_o,

    input  board_pad_pkg::sfp_status_t sfp_status_i,
    output board_pad_pkg::sfp_status_t sfp_status_sync_o,

    input  board_pad_pkg::i2c_lines_t  i2c_o_i,
    input  board_pad_pkg::i2c_lines_t  i2c_t_i,
    output board_pad_pkg::i2c_lines_t  i2c_sync_o,
    inout  wire                        sfp_i2c_scl_io,
    inout  wire                        sfp_1_i2c_sda_io,
    inout  wire                        sfp_2_i2c_sda_io,
    inout  wire                        eeprom_i2c_scl_io,
    inout  wire                        eeprom_i2c_sda_io,

    input  board_pad_pkg::flash_data_t flash_dq_o_i,
    input  logic                       flash_dq_oe_i,
    input  board_pad_pkg::flash_addr_t flash_addr_i,
    input  logic                       flash_region_i,
    input  logic                       flash_region_oe_i,
    input  logic                       flash_ce_n_i,
    input  logic                       flash_oe_n_i,
    input  logic                       flash_we_n_i,
    input  logic                       flash_adv_n_i,
    output board_pad_pkg::flash_data_t flash_dq_sync_o,
    inout  wire board_pad_pkg::flash_data_t flash_dq_io,
    inout  wire                        flash_region_io,
    output board_pad_pkg::flash_addr_t flash_addr_o,
    output logic                       flash_ce_n_o,
    output logic                       flash_oe_n_o,
    output logic                       flash_we_n_o,
    output logic                       flash_adv_n_o
);

    import board_pad_pkg::*;

    logic       boot_req;
    i2c_lines_t i2c_pad;

    // Pad levels as seen on the board, driven or released
    assign i2c_pad[I2C_SFP_SCL]    = sfp_i2c_scl_io;
    assign i2c_pad[I2C_SFP1_SDA]   = sfp_1_i2c_sda_io;
    assign i2c_pad[I2C_SFP2_SDA]   = sfp_2_i2c_sda_io;
    assign i2c_pad[I2C_EEPROM_SCL] = eeprom_i2c_scl_io;
    assign i2c_pad[I2C_EEPROM_SDA] = eeprom_i2c_sda_io;

    pad_input_sync u_input_sync (
        .pcie_user_clk     (pcie_user_clk),
        .arst_n_i          (arst_n_i),
        .fpga_boot_i       (fpga_boot_i),
        .sfp_status_i      (sfp_status_i),
        .i2c_pad_i         (i2c_pad),
        .flash_dq_pad_i    (flash_dq_io),
        .boot_req_o        (boot_req),
        .sfp_status_sync_o (sfp_status_sync_o),
        .i2c_sync_o        (i2c_sync_o),
        .flash_dq_sync_o   (flash_dq_sync_o)
    );

    icap_reboot_seq u_reboot_seq (
        .pcie_user_clk (pcie_user_clk),
        .arst_n_i      (arst_n_i),
        .boot_req_i    (boot_req),
        .icap_avail_i  (icap_avail_i),
        .icap_csib_o   (icap_csib_o),
        .icap_rdwrb_o  (icap_rdwrb_o),
        .icap_di_o     (icap_di_o)
    );

    pad_output_stage u_output_stage (
        .pcie_user_clk     (pcie_user_clk),
        .arst_n_i          (arst_n_i),
        .i2c_o_i           (i2c_o_i),
        .i2c_t_i           (i2c_t_i),
        .sfp_i2c_scl_io    (sfp_i2c_scl_io),
        .sfp_1_i2c_sda_io  (sfp_1_i2c_sda_io),
        .sfp_2_i2c_sda_io  (sfp_2_i2c_sda_io),
        .eeprom_i2c_scl_io (eeprom_i2c_scl_io),
        .eeprom_i2c_sda_io (eeprom_i2c_sda_io),
        .flash_dq_o_i      (flash_dq_o_i),
        .flash_dq_oe_i     (flash_dq_oe_i),
        .flash_addr_i      (flash_addr_i),
        .flash_region_i    (flash_region_i),
        .flash_region_oe_i (flash_region_oe_i),
        .flash_ce_n_i      (flash_ce_n_i),
        .flash_oe_n_i      (flash_oe_n_i),
        .flash_we_n_i      (flash_we_n_i),
        .flash_adv_n_i     (flash_adv_n_i),
        .flash_dq_io       (flash_dq_io),
        .flash_region_io   (flash_region_io),
        .flash_addr_o      (flash_addr_o),
        .flash_ce_n_o      (flash_ce_n_o),
        .flash_oe_n_o      (flash_oe_n_o),
        .flash_we_n_o      (flash_we_n_o),
        .flash_adv_n_o     (flash_adv_n_o)
    );

endmodule

// File: tb/board_io_tb.sv
// Stops at the first mismatch; a board-side model drives the flash bus whenever the FPGA enable is low
module board_io_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import board_pad_pkg::*;
    import icap_cmd_pkg::*;

    localparam int TABLE_LEN  = 44;
    localparam int CLK_PERIOD = 8;

    typedef struct packed {
        logic        boot;
        logic        avail;
        i2c_lines_t  i2c_o;
        i2c_lines_t  i2c_t;
        flash_data_t dq_o;
        logic        dq_oe;
        flash_data_t tb_dq;
        flash_addr_t addr;
        logic        region;
        logic        region_oe;
        logic [3:0]  strobes;
        sfp_status_t sfp;
        // Expected at the falling edge, before this step is driven
        logic        exp_csib;
        icap_word_t  exp_di;
        logic [3:0]  exp_strobes;
        flash_addr_t exp_addr;
        logic        exp_region;
        flash_data_t exp_dq;
        flash_data_t exp_dq_sync;
        i2c_lines_t  exp_i2c;
        i2c_lines_t  exp_i2c_sync;
        sfp_status_t exp_sfp_sync;
    } step_t;

    logic        pcie_user_clk = 1'b0;
    logic        arst_n_i = 1'b0;
    logic        fpga_boot_i, icap_avail_i, icap_csib_o, icap_rdwrb_o;
    icap_word_t  icap_di_o;
    sfp_status_t sfp_status_i, sfp_status_sync_o;
    i2c_lines_t  i2c_o_i, i2c_t_i, i2c_sync_o;
    flash_data_t flash_dq_o_i, flash_dq_sync_o, tb_dq;
    flash_addr_t flash_addr_i, flash_addr_o;
    logic        flash_dq_oe_i, flash_region_i, flash_region_oe_i, dq_oe_mirror;
    logic        flash_ce_n_i, flash_oe_n_i, flash_we_n_i, flash_adv_n_i;
    logic        flash_ce_n_o, flash_oe_n_o, flash_we_n_o, flash_adv_n_o;
    wire         sfp_i2c_scl_io, sfp_1_i2c_sda_io, sfp_2_i2c_sda_io;
    wire         eeprom_i2c_scl_io, eeprom_i2c_sda_io, flash_region_io;
    wire flash_data_t flash_dq_io;
    wire i2c_lines_t  i2c_pads;

    integer seed = 91444;
    step_t  idle_step;
    step_t  steps [TABLE_LEN];

    board_io_top dut (.*);

    always #(CLK_PERIOD / 2) pcie_user_clk = ~pcie_user_clk;

    pullup (sfp_i2c_scl_io);
    pullup (sfp_1_i2c_sda_io);
    pullup (sfp_2_i2c_sda_io);
    pullup (eeprom_i2c_scl_io);
    pullup (eeprom_i2c_sda_io);
    pullup (flash_region_io);

    // Bit order follows the I2C line indices 4 down to 0
    assign i2c_pads = {eeprom_i2c_sda_io, eeprom_i2c_scl_io, sfp_2_i2c_sda_io,
                       sfp_1_i2c_sda_io, sfp_i2c_scl_io};

    // Flash-side buffer, released while the FPGA drives the bus
    always @(posedge pcie_user_clk or negedge arst_n_i) begin
        if (!arst_n_i)
            dq_oe_mirror <= 1'b0;
        else
            dq_oe_mirror <= flash_dq_oe_i;
    end
    assign flash_dq_io = dq_oe_mirror ? 'z : tb_dq;

    function automatic icap_word_t reverse_in_bytes(icap_word_t w);
        icap_word_t r;
        for (int i = 0; i < 32; i++) begin
            r[(i / 8) * 8 + 7 - (i % 8)] = w[i];
        end
        return r;
    endfunction

    function automatic step_t step_at(int j);
        return (j < 0) ? idle_step : steps[j];
    endfunction

    // Released line reads the pullup
    function automatic i2c_lines_t i2c_level(step_t s);
        return s.i2c_o | s.i2c_t;
    endfunction

    task automatic build_table();
        icap_word_t port_words [7] = '{'1, ICAP_DUMMY, ICAP_SYNC, ICAP_NOOP,
                                       ICAP_CMD_WRITE, ICAP_IPROG, ICAP_NOOP};
        step_t      prev;
        step_t      prev2;
        step_t      prev3;
        int         pos;
        for (int k = 0; k < TABLE_LEN; k++) begin
            steps[k] = idle_step;
            steps[k].i2c_o = i2c_lines_t'($random(seed));
            steps[k].i2c_t = i2c_lines_t'($random(seed));
            steps[k].dq_o = flash_data_t'($random(seed));
            steps[k].tb_dq = flash_data_t'($random(seed));
            steps[k].addr = flash_addr_t'($random(seed));
            {steps[k].dq_oe, steps[k].region, steps[k].region_oe} = 3'($random(seed));
            steps[k].strobes = 4'($random(seed));
            steps[k].sfp = sfp_status_t'($random(seed));
            // Short pulse, then a request that waits on availability
            steps[k].boot = (k >= 4 && k < 6) || (k >= 20 && k < 32);
            steps[k].avail = !(k >= 20 && k < 30);
        end
        pos = 0;
        for (int k = 0; k < TABLE_LEN; k++) begin
            prev  = step_at(k - 1);
            prev2 = step_at(k - 2);
            prev3 = step_at(k - 3);
            // Request reaches the sequencer three edges after it is sampled
            if (k > 0) begin
                if (pos == 6)
                    pos = 0;
                else if (pos > 0)
                    pos++;
                else if (step_at(k - 4).boot && prev.avail)
                    pos = 1;
            end
            steps[k].exp_csib = (pos == 0);
            steps[k].exp_di = reverse_in_bytes(port_words[pos]);
            steps[k].exp_strobes = prev.strobes;
            steps[k].exp_addr = prev.addr;
            steps[k].exp_region = prev.region_oe ? prev.region : 1'b1;
            steps[k].exp_dq = prev.dq_oe ? prev.dq_o : prev.tb_dq;
            steps[k].exp_i2c = i2c_level(prev);
            steps[k].exp_i2c_sync = (k < 2) ? '0 : i2c_level(prev3);
            steps[k].exp_dq_sync = (k < 2) ? '0 : (prev3.dq_oe ? prev3.dq_o : prev2.tb_dq);
            steps[k].exp_sfp_sync = (k < 2) ? '0 : prev2.sfp;
        end
    endtask

    task automatic check_value(string name, logic [31:0] actual, logic [31:0] expected);
        assert (actual === expected) else begin
            $display("** Error at %0t: %s expected %0h, actual %0h", $time, name, expected, actual);
            $display("Done: errors found");
            $fatal(1);
        end
    endtask

    task automatic check_step(step_t s);
        check_value("icap_csib_o", icap_csib_o, s.exp_csib);
        check_value("icap_rdwrb_o", icap_rdwrb_o, 1'b0);
        check_value("icap_di_o", icap_di_o, s.exp_di);
        check_value("flash_ce_n_o", flash_ce_n_o, s.exp_strobes[3]);
        check_value("flash_oe_n_o", flash_oe_n_o, s.exp_strobes[2]);
        check_value("flash_we_n_o", flash_we_n_o, s.exp_strobes[1]);
        check_value("flash_adv_n_o", flash_adv_n_o, s.exp_strobes[0]);
        check_value("flash_addr_o", flash_addr_o, s.exp_addr);
        check_value("flash_region_io", flash_region_io, s.exp_region);
        check_value("flash_dq_io", flash_dq_io, s.exp_dq);
        check_value("i2c pads", i2c_pads, s.exp_i2c);
        check_value("i2c_sync_o", i2c_sync_o, s.exp_i2c_sync);
        check_value("flash_dq_sync_o", flash_dq_sync_o, s.exp_dq_sync);
        check_value("sfp_status_sync_o", sfp_status_sync_o, s.exp_sfp_sync);
    endtask

    task automatic apply_step(step_t s);
        fpga_boot_i       = s.boot;
        icap_avail_i      = s.avail;
        i2c_o_i           = s.i2c_o;
        i2c_t_i           = s.i2c_t;
        flash_dq_o_i      = s.dq_o;
        flash_dq_oe_i     = s.dq_oe;
        tb_dq             = s.tb_dq;
        flash_addr_i      = s.addr;
        flash_region_i    = s.region;
        flash_region_oe_i = s.region_oe;
        {flash_ce_n_i, flash_oe_n_i, flash_we_n_i, flash_adv_n_i} = s.strobes;
        sfp_status_i      = s.sfp;
    endtask

    initial begin
        #(TABLE_LEN * 20 * CLK_PERIOD);
        $display("Watchdog expired before the step table was applied");
        $display("Done: errors found");
        $fatal(1);
    end

    initial begin
        // Quiet inputs matching the reset state of the pads
        idle_step         = '0;
        idle_step.avail   = 1'b1;
        idle_step.i2c_t   = '1;
        idle_step.tb_dq   = 16'hC35A;
        idle_step.strobes = 4'hF;
        build_table();
        apply_step(idle_step);
        repeat (4) @(negedge pcie_user_clk);
        check_value("icap_csib_o", icap_csib_o, 1'b1);
        check_value("icap_di_o", icap_di_o, 32'hFFFF_FFFF);
        check_value("flash strobes", {flash_ce_n_o, flash_oe_n_o, flash_we_n_o, flash_adv_n_o},
                    4'hF);
        check_value("flash_dq_io", flash_dq_io, idle_step.tb_dq);
        check_value("flash_region_io", flash_region_io, 1'b1);
        check_value("i2c pads", i2c_pads, 5'h1F);
        check_value("i2c_sync_o", i2c_sync_o, '0);
        check_value("flash_dq_sync_o", flash_dq_sync_o, '0);
        check_value("sfp_status_sync_o", sfp_status_sync_o, '0);
        arst_n_i = 1'b1;
        for (int k = 0; k < TABLE_LEN; k++) begin
            check_step(steps[k]);
            apply_step(steps[k]);
            @(negedge pcie_user_clk);
        end
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: flist.f
hw/board_pad_pkg.sv
hw/icap_cmd_pkg.sv
hw/pad_input_sync.sv
hw/icap_reboot_seq.sv
hw/pad_output_stage.sv
hw/board_io_top.sv
tb/board_io_tb.sv

// File: Bender.yml
package:
  name: board_io

sources:
  - hw/board_pad_pkg.sv
  - hw/icap_cmd_pkg.sv
  - hw/pad_input_sync.sv
  - hw/icap_reboot_seq.sv
  - hw/pad_output_stage.sv
  - hw/board_io_top.sv
  - target: test
    files:
      - tb/board_io_tb.sv
